//--- Makefile
SIM  := obj_dir/Vtb_wb_top
SRCS := $(wildcard *.sv)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) build.f
	verilator --binary --timing --assert -f build.f --top-module tb_wb_top --Mdir obj_dir

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q '^>>> PASS$$' sim.log

clean:
	rm -rf obj_dir sim.log

//--- build.f
wb_pkg.sv
mem_result_align.sv
wb_pipe_slice.sv
wb_commit.sv
wb_subsystem_top.sv
tb_wb_checker.sv
tb_wb_top.sv

//--- mem_result_align.sv
// load data aligner: byte/halfword select, sign or zero extension, alu pass
`default_nettype none

module mem_result_align import wb_pkg::*; (
    input  wire logic            clk,
    input  wire logic            reset,

    input  wire logic            in_valid_i,
    output logic                 in_ready_o,
    output logic                 out_valid_o,
    input  wire logic            out_ready_i,

    input  wire wb_op_e          op_i,
    input  wire logic [XLEN-1:0] alu_result_i,
    input  wire logic [XLEN-1:0] load_word_i,
    output logic [XLEN-1:0]      gpr_wdata_o
);

    logic [1:0]  offset;
    logic [7:0]  ld_byte;
    logic [15:0] ld_half;

    // handshake is untouched, only data is reshaped
    assign out_valid_o = in_valid_i;
    assign in_ready_o  = out_ready_i;

    // byte offset of the access
    assign offset = alu_result_i[1:0];

    always_comb begin
        case (offset)
            2'd0:    ld_byte = load_word_i[7:0];
            2'd1:    ld_byte = load_word_i[15:8];
            2'd2:    ld_byte = load_word_i[23:16];
            default: ld_byte = load_word_i[31:24];
        endcase
    end

    // halfword offsets are even, bit 1 picks the half
    assign ld_half = offset[1] ? load_word_i[31:16] : load_word_i[15:0];

    always_comb begin
        case (op_i)
            OP_ALU:  gpr_wdata_o = alu_result_i;
            OP_LB:   gpr_wdata_o = {{(XLEN-8){ld_byte[7]}}, ld_byte};
            OP_LBU:  gpr_wdata_o = {{(XLEN-8){1'b0}}, ld_byte};
            OP_LH:   gpr_wdata_o = {{(XLEN-16){ld_half[15]}}, ld_half};
            OP_LHU:  gpr_wdata_o = {{(XLEN-16){1'b0}}, ld_half};
            OP_LW:   gpr_wdata_o = load_word_i;
            // no register value for OP_NONE
            default: gpr_wdata_o = '0;
        endcase
    end

    // misaligned halfword loads never reach writeback
    property p_half_aligned;
        @(posedge clk) disable iff (reset)
        (in_valid_i && (op_i == OP_LH || op_i == OP_LHU)) |-> !alu_result_i[0];
    endproperty

    a_half_aligned: assert property (p_half_aligned)
        else $error("halfword load with odd offset %0d", offset);

endmodule

`default_nettype wire

//--- tb_wb_checker.sv
// testbench checker with expected item queue, retire compare, gpr dump compare and error counts
`default_nettype none

module tb_wb_checker import wb_pkg::*; #(
    parameter int PIPE_DEPTH = 2
) (
    input  wire logic                  clk,
    input  wire logic                  reset,

    input  wire logic                  in_valid_i,
    input  wire logic                  in_ready_i,
    input  wire wb_op_e                op_i,
    input  wire logic [GPR_ADDR_W-1:0] rd_i,
    input  wire logic                  gpr_we_i,
    input  wire logic [XLEN-1:0]       alu_result_i,
    input  wire logic [XLEN-1:0]       load_word_i,
    input  wire logic                  csr_we_i,
    input  wire logic [CSR_ADDR_W-1:0] csr_addr_i,
    input  wire logic [XLEN-1:0]       csr_wdata_i,
    input  wire logic                  irq_i,
    input  wire logic [IRQ_NO_W-1:0]   irq_no_i,
    input  wire logic                  flush_i,

    input  wire logic                  retire_valid_i,
    input  wire logic                  retire_gpr_we_i,
    input  wire logic [GPR_ADDR_W-1:0] retire_rd_i,
    input  wire logic [XLEN-1:0]       retire_gpr_data_i,
    input  wire logic                  retire_csr_we_i,
    input  wire logic [CSR_ADDR_W-1:0] retire_csr_addr_i,
    input  wire logic [XLEN-1:0]       retire_csr_data_i,
    input  wire logic                  retire_irq_i,

    input  wire logic                  halted_i,
    input  wire logic [GPR_ADDR_W-1:0] dbg_rd_i,
    input  wire logic [XLEN-1:0]       dbg_gpr_data_i,
    input  wire logic                  dump_en_i,
    input  wire logic                  report_i,
    output int                         error_count_o
);
    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        logic                  gpr_we;
        logic [GPR_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       gpr_data;
        logic                  csr_we;
        logic [CSR_ADDR_W-1:0] csr_addr;
        logic [XLEN-1:0]       csr_data;
        logic                  irq;
    } exp_item_t;

    exp_item_t       exp_q [$];
    logic [XLEN-1:0] model_gpr [1 << GPR_ADDR_W];
    logic            halted_prev = 1'b0;
    logic            reported = 1'b0;
    int              mismatch_cnt = 0;
    int              unexpected_cnt = 0;
    int              halt_cnt = 0;
    int              n_retired = 0;
    int              post_halt_acc = 0;

    assign error_count_o = mismatch_cnt + unexpected_cnt + halt_cnt;

    // register value a load or alu item should produce
    function automatic logic [XLEN-1:0] aligned_value(wb_op_e op, logic [XLEN-1:0] addr,
                                                      logic [XLEN-1:0] word);
        logic [XLEN-1:0] sh;
        sh = word >> (8 * addr[1:0]);
        case (op)
            OP_ALU:  return addr;
            OP_LB:   return {{(XLEN-8){sh[7]}}, sh[7:0]};
            OP_LBU:  return {{(XLEN-8){1'b0}}, sh[7:0]};
            OP_LH:   return {{(XLEN-16){sh[15]}}, sh[15:0]};
            OP_LHU:  return {{(XLEN-16){1'b0}}, sh[15:0]};
            OP_LW:   return word;
            default: return '0;
        endcase
    endfunction

    function automatic logic implemented_csr(logic [CSR_ADDR_W-1:0] addr);
        return addr == CSR_MSTATUS || addr == CSR_MTVEC || addr == CSR_MSCRATCH ||
               addr == CSR_MEPC || addr == CSR_MCAUSE;
    endfunction

    // irq replaces the item's gpr and csr effects with an mcause write
    function automatic exp_item_t expected_item();
        exp_item_t e;
        e.rd       = rd_i;
        e.gpr_data = aligned_value(op_i, alu_result_i, load_word_i);
        e.irq      = irq_i;
        if (irq_i) begin
            // interrupt flag in the top bit, irq number in the low bits
            e.gpr_we   = 1'b0;
            e.csr_we   = 1'b1;
            e.csr_addr = CSR_MCAUSE;
            e.csr_data = (XLEN'(1) << (XLEN-1)) | XLEN'(irq_no_i);
        end else begin
            e.gpr_we   = gpr_we_i && (rd_i != '0);
            e.csr_we   = csr_we_i && implemented_csr(csr_addr_i);
            e.csr_addr = csr_addr_i;
            e.csr_data = csr_wdata_i;
        end
        return e;
    endfunction

    task automatic compare_field(string name, logic [XLEN-1:0] got, logic [XLEN-1:0] exp);
        if (got !== exp) begin
            mismatch_cnt++;
            $display("Mismatch at %0t: retire %0d field %s got %h expected %h",
                     $time, n_retired, name, got, exp);
        end
    endtask

    task automatic check_retire();
        exp_item_t e;
        if (exp_q.size() == 0) begin
            unexpected_cnt++;
            $display("error at %0t: retire with no accepted item outstanding", $time);
        end else begin
            e = exp_q.pop_front();
            compare_field("gpr_we", XLEN'(retire_gpr_we_i), XLEN'(e.gpr_we));
            compare_field("rd", XLEN'(retire_rd_i), XLEN'(e.rd));
            compare_field("gpr_data", retire_gpr_data_i, e.gpr_data);
            compare_field("csr_we", XLEN'(retire_csr_we_i), XLEN'(e.csr_we));
            compare_field("irq", XLEN'(retire_irq_i), XLEN'(e.irq));
            if (e.csr_we) begin
                compare_field("csr_addr", XLEN'(retire_csr_addr_i), XLEN'(e.csr_addr));
                compare_field("csr_data", retire_csr_data_i, e.csr_data);
            end
            if (e.gpr_we) begin
                model_gpr[e.rd] = e.gpr_data;
            end
            n_retired++;
        end
    endtask

    // compare mid cycle while inputs and outputs are settled
    always @(negedge clk) begin
        if (reset) begin
            exp_q.delete();
            for (int i = 0; i < (1 << GPR_ADDR_W); i++) begin
                model_gpr[i] = '0;
            end
            halted_prev   = 1'b0;
            post_halt_acc = 0;
        end else begin
            if (retire_valid_i && halted_prev) begin
                halt_cnt++;
                $display("error at %0t: an item retired after the halt", $time);
            end else if (retire_valid_i) begin
                check_retire();
            end
            // an item accepted in the flush cycle is dropped with the rest
            if (flush_i) begin
                exp_q.delete();
            end else if (in_valid_i && in_ready_i) begin
                exp_q.push_back(expected_item());
                if (halted_i) begin
                    post_halt_acc++;
                end
                if (halted_i && post_halt_acc > PIPE_DEPTH) begin
                    halt_cnt++;
                    $display("error at %0t: input still accepting items after halt", $time);
                end
            end
            if (dump_en_i && dbg_gpr_data_i !== model_gpr[dbg_rd_i]) begin
                mismatch_cnt++;
                $display("Mismatch at %0t: x%0d reads %h expected %h", $time, dbg_rd_i,
                         dbg_gpr_data_i, model_gpr[dbg_rd_i]);
            end
            if (report_i && !reported) begin
                if (!halted_i || in_ready_i) begin
                    halt_cnt++;
                    $display("error: at the end the core is not halted with input blocked");
                end
                reported = 1'b1;
                $display("errors: mismatch %0d, unexpected retire %0d, halt %0d (retired %0d)",
                         mismatch_cnt, unexpected_cnt, halt_cnt, n_retired);
            end
            halted_prev = halted_i;
        end
    end

endmodule

`default_nettype wire

//--- tb_wb_top.sv
// testbench top: clock, reset, lfsr stimulus, dut, checker, timeout and gpr dump
`default_nettype none

module tb_wb_top import wb_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int PIPE_DEPTH  = 2;
    localparam int N_ITEMS     = 2000;
    localparam int HALT_TAIL   = 30;
    // four cycles per item leaves room for stalls, flushes and the halt tail
    localparam int CYCLE_LIMIT = 4 * N_ITEMS + 200;

    logic                  clk = 1'b0;
    logic                  reset;
    logic                  in_valid_i, in_ready_o;
    wb_op_e                op_i;
    logic [GPR_ADDR_W-1:0] rd_i;
    logic                  gpr_we_i;
    logic [XLEN-1:0]       alu_result_i, load_word_i;
    logic                  csr_we_i;
    logic [CSR_ADDR_W-1:0] csr_addr_i;
    logic [XLEN-1:0]       csr_wdata_i;
    logic                  irq_i;
    logic [IRQ_NO_W-1:0]   irq_no_i;
    logic                  is_break_i, flush_i, stall_i;
    logic                  retire_valid_o, retire_gpr_we_o, retire_csr_we_o, retire_irq_o;
    logic [GPR_ADDR_W-1:0] retire_rd_o;
    logic [XLEN-1:0]       retire_gpr_data_o, retire_csr_data_o;
    logic [CSR_ADDR_W-1:0] retire_csr_addr_o;
    logic                  halted_o;
    logic [GPR_ADDR_W-1:0] dbg_rd_i;
    logic [XLEN-1:0]       dbg_gpr_data_o;

    logic                  dump_en, report;
    int                    error_count;
    int                    cycle_cnt = 0;
    logic [31:0]           lfsr_q = 32'h89c073da;
    logic                  acc_s, hold_s, halt_s;

    always #4 clk = ~clk;

    wb_subsystem_top #(.PIPE_DEPTH(PIPE_DEPTH)) dut_i (
        .clk(clk), .reset(reset),
        .in_valid_i(in_valid_i), .in_ready_o(in_ready_o),
        .op_i(op_i), .rd_i(rd_i), .gpr_we_i(gpr_we_i),
        .alu_result_i(alu_result_i), .load_word_i(load_word_i),
        .csr_we_i(csr_we_i), .csr_addr_i(csr_addr_i), .csr_wdata_i(csr_wdata_i),
        .irq_i(irq_i), .irq_no_i(irq_no_i), .is_break_i(is_break_i),
        .flush_i(flush_i), .stall_i(stall_i),
        .retire_valid_o(retire_valid_o), .retire_gpr_we_o(retire_gpr_we_o),
        .retire_rd_o(retire_rd_o), .retire_gpr_data_o(retire_gpr_data_o),
        .retire_csr_we_o(retire_csr_we_o), .retire_csr_addr_o(retire_csr_addr_o),
        .retire_csr_data_o(retire_csr_data_o), .retire_irq_o(retire_irq_o),
        .halted_o(halted_o), .dbg_rd_i(dbg_rd_i), .dbg_gpr_data_o(dbg_gpr_data_o)
    );

    tb_wb_checker #(.PIPE_DEPTH(PIPE_DEPTH)) u_checker (
        .clk(clk), .reset(reset),
        .in_valid_i(in_valid_i), .in_ready_i(in_ready_o),
        .op_i(op_i), .rd_i(rd_i), .gpr_we_i(gpr_we_i),
        .alu_result_i(alu_result_i), .load_word_i(load_word_i),
        .csr_we_i(csr_we_i), .csr_addr_i(csr_addr_i), .csr_wdata_i(csr_wdata_i),
        .irq_i(irq_i), .irq_no_i(irq_no_i), .flush_i(flush_i),
        .retire_valid_i(retire_valid_o), .retire_gpr_we_i(retire_gpr_we_o),
        .retire_rd_i(retire_rd_o), .retire_gpr_data_i(retire_gpr_data_o),
        .retire_csr_we_i(retire_csr_we_o), .retire_csr_addr_i(retire_csr_addr_o),
        .retire_csr_data_i(retire_csr_data_o), .retire_irq_i(retire_irq_o),
        .halted_i(halted_o), .dbg_rd_i(dbg_rd_i), .dbg_gpr_data_i(dbg_gpr_data_o),
        .dump_en_i(dump_en), .report_i(report), .error_count_o(error_count)
    );

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one lfsr step per bit taken
    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
    endtask

    // five implemented csrs and three that are not
    function automatic logic [CSR_ADDR_W-1:0] pick_csr(logic [2:0] idx);
        case (idx)
            3'd0:    return CSR_MSTATUS;
            3'd1:    return CSR_MTVEC;
            3'd2:    return CSR_MSCRATCH;
            3'd3:    return CSR_MEPC;
            3'd4:    return CSR_MCAUSE;
            3'd5:    return 12'h304;
            3'd6:    return 12'h7c0;
            default: return 12'hf14;
        endcase
    endfunction

    task automatic drive_ctrl(input logic allow_flush);
        logic [31:0] r;
        take_bits(2, r);
        stall_i <= (r[1:0] == 2'd0);
        take_bits(7, r);
        flush_i <= allow_flush && (r[6:0] == 7'd0);
    endtask

    task automatic drive_item();
        logic [31:0] r;
        logic [31:0] addr;
        wb_op_e      op;
        take_bits(2, r);
        in_valid_i <= (r[1:0] != 2'd0);
        take_bits(3, r);
        op = (r[2:0] == 3'd7) ? OP_LW : wb_op_e'(r[2:0]);
        take_bits(32, addr);
        // halfword loads keep an even offset
        if (op == OP_LH || op == OP_LHU) begin
            addr[0] = 1'b0;
        end
        op_i         <= op;
        alu_result_i <= addr;
        take_bits(32, r);
        load_word_i  <= r;
        take_bits(4, r);
        rd_i         <= r[GPR_ADDR_W-1:0];
        take_bits(1, r);
        gpr_we_i     <= r[0];
        take_bits(2, r);
        csr_we_i     <= (r[1:0] == 2'd0);
        take_bits(3, r);
        csr_addr_i   <= pick_csr(r[2:0]);
        take_bits(32, r);
        csr_wdata_i  <= r;
        take_bits(4, r);
        irq_i        <= (r[3:0] == 4'd0);
        take_bits(4, r);
        irq_no_i     <= r[IRQ_NO_W-1:0];
        is_break_i   <= 1'b0;
    endtask

    task automatic drive_break();
        logic [31:0] r;
        take_bits(32, r);
        in_valid_i   <= 1'b1;
        op_i         <= OP_ALU;
        alu_result_i <= r;
        take_bits(4, r);
        rd_i         <= r[GPR_ADDR_W-1:0];
        gpr_we_i     <= 1'b1;
        csr_we_i     <= 1'b0;
        irq_i        <= 1'b0;
        is_break_i   <= 1'b1;
    endtask

    // handshake sampled mid cycle, then on to the next rising edge
    task automatic wait_edge();
        @(negedge clk);
        acc_s  = in_valid_i && in_ready_o;
        hold_s = in_valid_i && !in_ready_o;
        halt_s = halted_o;
        @(posedge clk);
    endtask

    initial begin
        int n_acc;
        int n_tail;
        n_acc        = 0;
        n_tail       = 0;
        reset        = 1'b1;
        in_valid_i   = 1'b0;
        op_i         = OP_NONE;
        rd_i         = '0;
        gpr_we_i     = 1'b0;
        alu_result_i = '0;
        load_word_i  = '0;
        csr_we_i     = 1'b0;
        csr_addr_i   = '0;
        csr_wdata_i  = '0;
        irq_i        = 1'b0;
        irq_no_i     = '0;
        is_break_i   = 1'b0;
        flush_i      = 1'b0;
        stall_i      = 1'b0;
        dbg_rd_i     = '0;
        dump_en      = 1'b0;
        report       = 1'b0;
        hold_s       = 1'b0;
        acc_s        = 1'b0;
        halt_s       = 1'b0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        // random traffic, a pending item is held until taken
        while (n_acc < N_ITEMS) begin
            drive_ctrl(1'b1);
            if (!hold_s) begin
                drive_item();
            end
            wait_edge();
            if (acc_s) begin
                n_acc++;
            end
        end
        drive_ctrl(1'b0);
        drive_break();
        wait_edge();
        while (!acc_s) begin
            drive_ctrl(1'b0);
            wait_edge();
        end
        // keep offering items so the slices fill behind the halted commit
        while (n_tail < HALT_TAIL) begin
            drive_ctrl(1'b0);
            if (!hold_s) begin
                drive_item();
            end
            wait_edge();
            if (halt_s) begin
                n_tail++;
            end
        end
        in_valid_i <= 1'b0;
        flush_i    <= 1'b0;
        dump_en    <= 1'b1;
        for (int r = 0; r < (1 << GPR_ADDR_W); r++) begin
            dbg_rd_i <= GPR_ADDR_W'(r);
            @(posedge clk);
        end
        dump_en <= 1'b0;
        report  <= 1'b1;
        @(posedge clk);
        if (error_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout: run not finished after %0d cycles", CYCLE_LIMIT);
            $display(">>> FAIL");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- wb_commit.sv
// commit unit: gpr file, machine csrs, irq cause, halt fsm, retire trace
`default_nettype none

module wb_commit import wb_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  reset,

    input  wire logic                  in_valid_i,
    output logic                       in_ready_o,
    input  wire logic                  stall_i,

    input  wire logic [GPR_ADDR_W-1:0] rd_i,
    input  wire logic                  gpr_we_i,
    input  wire logic [XLEN-1:0]       gpr_wdata_i,
    input  wire logic                  csr_we_i,
    input  wire logic [CSR_ADDR_W-1:0] csr_addr_i,
    input  wire logic [XLEN-1:0]       csr_wdata_i,
    input  wire logic                  irq_i,
    input  wire logic [IRQ_NO_W-1:0]   irq_no_i,
    input  wire logic                  is_break_i,

    output logic                       retire_valid_o,
    output logic                       retire_gpr_we_o,
    output logic [GPR_ADDR_W-1:0]      retire_rd_o,
    output logic [XLEN-1:0]            retire_gpr_data_o,
    output logic                       retire_csr_we_o,
    output logic [CSR_ADDR_W-1:0]      retire_csr_addr_o,
    output logic [XLEN-1:0]            retire_csr_data_o,
    output logic                       retire_irq_o,

    output logic                       halted_o,
    input  wire logic [GPR_ADDR_W-1:0] dbg_rd_i,
    output logic [XLEN-1:0]            dbg_gpr_data_o
);

    localparam int NUM_GPR = 1 << GPR_ADDR_W;

    commit_state_e state_q;

    logic [XLEN-1:0]       gpr_q [NUM_GPR];
    logic [XLEN-1:0]       mstatus_q, mtvec_q, mscratch_q, mepc_q, mcause_q;

    logic                  consume;
    logic                  csr_hit;
    logic                  gpr_wr;
    logic                  csr_wr;
    logic [CSR_ADDR_W-1:0] csr_wr_addr;
    logic [XLEN-1:0]       csr_wr_data;
    logic [XLEN-1:0]       irq_cause;

    assign in_ready_o = (state_q == ST_RUN) && !stall_i;
    assign consume    = in_valid_i && in_ready_o;
    assign halted_o   = (state_q == ST_HALTED);

    always_comb begin
        case (csr_addr_i)
            CSR_MSTATUS, CSR_MTVEC, CSR_MSCRATCH, CSR_MEPC, CSR_MCAUSE: csr_hit = 1'b1;
            default: csr_hit = 1'b0;
        endcase
    end

    // interrupt: mcause write replaces the item's own csr and gpr effects
    assign irq_cause   = {1'b1, {(XLEN-1-IRQ_NO_W){1'b0}}, irq_no_i};
    assign gpr_wr      = consume && gpr_we_i && !irq_i && (rd_i != '0);
    assign csr_wr      = consume && (irq_i || (csr_we_i && csr_hit));
    assign csr_wr_addr = irq_i ? CSR_ADDR_W'(CSR_MCAUSE) : csr_addr_i;
    assign csr_wr_data = irq_i ? irq_cause : csr_wdata_i;

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= ST_RUN;
        end else if (consume && is_break_i) begin
            state_q <= ST_HALTED;
        end
    end

    // x0 is never written and stays zero
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_GPR; i++) begin
                gpr_q[i] <= '0;
            end
        end else if (gpr_wr) begin
            gpr_q[rd_i] <= gpr_wdata_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mstatus_q  <= '0;
            mtvec_q    <= '0;
            mscratch_q <= '0;
            mepc_q     <= '0;
            mcause_q   <= '0;
        end else if (csr_wr) begin
            case (csr_wr_addr)
                CSR_MSTATUS:  mstatus_q  <= csr_wr_data;
                CSR_MTVEC:    mtvec_q    <= csr_wr_data;
                CSR_MSCRATCH: mscratch_q <= csr_wr_data;
                CSR_MEPC:     mepc_q     <= csr_wr_data;
                CSR_MCAUSE:   mcause_q   <= csr_wr_data;
                default:      mcause_q   <= mcause_q;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            retire_valid_o <= 1'b0;
        end else begin
            retire_valid_o <= consume;
        end
    end

    // trace fields only mean something with retire_valid_o
    always_ff @(posedge clk) begin
        if (consume) begin
            retire_gpr_we_o   <= gpr_wr;
            retire_rd_o       <= rd_i;
            retire_gpr_data_o <= gpr_wdata_i;
            retire_csr_we_o   <= csr_wr;
            retire_csr_addr_o <= csr_wr_addr;
            retire_irq_o      <= irq_i;
        end
    end

    // committed csr value, read back from the csr file itself
    always_comb begin
        case (retire_csr_addr_o)
            CSR_MSTATUS:  retire_csr_data_o = mstatus_q;
            CSR_MTVEC:    retire_csr_data_o = mtvec_q;
            CSR_MSCRATCH: retire_csr_data_o = mscratch_q;
            CSR_MEPC:     retire_csr_data_o = mepc_q;
            CSR_MCAUSE:   retire_csr_data_o = mcause_q;
            default:      retire_csr_data_o = '0;
        endcase
    end

    assign dbg_gpr_data_o = (dbg_rd_i == '0) ? '0 : gpr_q[dbg_rd_i];

    // the break retire is the last one
    property p_no_retire_halted;
        @(posedge clk) disable iff (reset)
        halted_o |=> !retire_valid_o;
    endproperty

    a_no_retire_halted: assert property (p_no_retire_halted)
        else $error("retire seen after halt");

endmodule

`default_nettype wire

//--- wb_pipe_slice.sv
// flushable valid/ready register slice carrying one writeback item
`default_nettype none

module wb_pipe_slice import wb_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  flush_i,

    input  wire logic                  in_valid_i,
    output logic                       in_ready_o,
    output logic                       out_valid_o,
    input  wire logic                  out_ready_i,

    input  wire logic [GPR_ADDR_W-1:0] rd_i,
    input  wire logic                  gpr_we_i,
    input  wire logic [XLEN-1:0]       gpr_wdata_i,
    input  wire logic                  csr_we_i,
    input  wire logic [CSR_ADDR_W-1:0] csr_addr_i,
    input  wire logic [XLEN-1:0]       csr_wdata_i,
    input  wire logic                  irq_i,
    input  wire logic [IRQ_NO_W-1:0]   irq_no_i,
    input  wire logic                  is_break_i,

    output logic [GPR_ADDR_W-1:0]      rd_o,
    output logic                       gpr_we_o,
    output logic [XLEN-1:0]            gpr_wdata_o,
    output logic                       csr_we_o,
    output logic [CSR_ADDR_W-1:0]      csr_addr_o,
    output logic [XLEN-1:0]            csr_wdata_o,
    output logic                       irq_o,
    output logic [IRQ_NO_W-1:0]        irq_no_o,
    output logic                       is_break_o
);

    logic valid_q;
    logic accept;
    logic send;

    // take a new item when empty or when the held one leaves now
    assign in_ready_o  = !valid_q || out_ready_i;
    // killed items are hidden in the flush cycle itself
    assign out_valid_o = valid_q && !flush_i;

    assign accept = in_valid_i && in_ready_o;
    assign send   = out_valid_o && out_ready_i;

    always_ff @(posedge clk) begin
        if (reset || flush_i) begin
            valid_q <= 1'b0;
        end else if (accept) begin
            valid_q <= 1'b1;
        end else if (send) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush_i) begin
            rd_o        <= '0;
            gpr_we_o    <= 1'b0;
            gpr_wdata_o <= '0;
            csr_we_o    <= 1'b0;
            csr_addr_o  <= '0;
            csr_wdata_o <= '0;
            irq_o       <= 1'b0;
            irq_no_o    <= '0;
            is_break_o  <= 1'b0;
        end else if (accept) begin
            rd_o        <= rd_i;
            gpr_we_o    <= gpr_we_i;
            gpr_wdata_o <= gpr_wdata_i;
            csr_we_o    <= csr_we_i;
            csr_addr_o  <= csr_addr_i;
            csr_wdata_o <= csr_wdata_i;
            irq_o       <= irq_i;
            irq_no_o    <= irq_no_i;
            is_break_o  <= is_break_i;
        end
    end

    // a stalled item must not change under the consumer
    property p_hold_payload;
        @(posedge clk) disable iff (reset)
        (out_valid_o && !out_ready_i) |=> $stable({rd_o, gpr_we_o, gpr_wdata_o, csr_we_o,
                                                   csr_addr_o, csr_wdata_o, irq_o, irq_no_o,
                                                   is_break_o});
    endproperty

    a_hold_payload: assert property (p_hold_payload)
        else $error("slice payload changed while stalled");

endmodule

`default_nettype wire

//--- wb_pkg.sv
// writeback widths, opcode enum, csr address enum and commit state enum
`default_nettype none

package wb_pkg;

    // datapath and field widths
    localparam int XLEN       = 32;
    localparam int GPR_ADDR_W = 4;
    localparam int CSR_ADDR_W = 12;
    localparam int IRQ_NO_W   = 4;

    // writeback opcode, picks where the register value comes from
    typedef enum logic [2:0] {
        OP_NONE = 3'd0,
        OP_ALU  = 3'd1,
        OP_LB   = 3'd2,
        OP_LH   = 3'd3,
        OP_LW   = 3'd4,
        OP_LBU  = 3'd5,
        OP_LHU  = 3'd6
    } wb_op_e;

    // implemented machine csrs
    typedef enum logic [CSR_ADDR_W-1:0] {
        CSR_MSTATUS  = 12'h300,
        CSR_MTVEC    = 12'h305,
        CSR_MSCRATCH = 12'h340,
        CSR_MEPC     = 12'h341,
        CSR_MCAUSE   = 12'h342
    } csr_addr_e;

    // commit unit state
    typedef enum logic {
        ST_RUN    = 1'b0,
        ST_HALTED = 1'b1
    } commit_state_e;

endpackage

`default_nettype wire

//--- wb_subsystem_top.sv
// writeback subsystem: aligner, chain of pipe slices, commit unit
`default_nettype none

module wb_subsystem_top import wb_pkg::*; #(
    parameter int PIPE_DEPTH = 2
) (
    input  wire logic                  clk,
    input  wire logic                  reset,

    input  wire logic                  in_valid_i,
    output logic                       in_ready_o,
    input  wire wb_op_e                op_i,
    input  wire logic [GPR_ADDR_W-1:0] rd_i,
    input  wire logic                  gpr_we_i,
    input  wire logic [XLEN-1:0]       alu_result_i,
    input  wire logic [XLEN-1:0]       load_word_i,
    input  wire logic                  csr_we_i,
    input  wire logic [CSR_ADDR_W-1:0] csr_addr_i,
    input  wire logic [XLEN-1:0]       csr_wdata_i,
    input  wire logic                  irq_i,
    input  wire logic [IRQ_NO_W-1:0]   irq_no_i,
    input  wire logic                  is_break_i,

    input  wire logic                  flush_i,
    input  wire logic                  stall_i,

    output logic                       retire_valid_o,
    output logic                       retire_gpr_we_o,
    output logic [GPR_ADDR_W-1:0]      retire_rd_o,
    output logic [XLEN-1:0]            retire_gpr_data_o,
    output logic                       retire_csr_we_o,
    output logic [CSR_ADDR_W-1:0]      retire_csr_addr_o,
    output logic [XLEN-1:0]            retire_csr_data_o,
    output logic                       retire_irq_o,

    output logic                       halted_o,
    input  wire logic [GPR_ADDR_W-1:0] dbg_rd_i,
    output logic [XLEN-1:0]            dbg_gpr_data_o
);

    // stage k feeds slice k, stage PIPE_DEPTH feeds commit
    logic                  s_valid     [PIPE_DEPTH+1];
    logic                  s_ready     [PIPE_DEPTH+1];
    logic [GPR_ADDR_W-1:0] s_rd        [PIPE_DEPTH+1];
    logic                  s_gpr_we    [PIPE_DEPTH+1];
    logic [XLEN-1:0]       s_gpr_wdata [PIPE_DEPTH+1];
    logic                  s_csr_we    [PIPE_DEPTH+1];
    logic [CSR_ADDR_W-1:0] s_csr_addr  [PIPE_DEPTH+1];
    logic [XLEN-1:0]       s_csr_wdata [PIPE_DEPTH+1];
    logic                  s_irq       [PIPE_DEPTH+1];
    logic [IRQ_NO_W-1:0]   s_irq_no    [PIPE_DEPTH+1];
    logic                  s_is_break  [PIPE_DEPTH+1];

    mem_result_align u_align (
        .clk          (clk),
        .reset        (reset),
        .in_valid_i   (in_valid_i),
        .in_ready_o   (in_ready_o),
        .out_valid_o  (s_valid[0]),
        .out_ready_i  (s_ready[0]),
        .op_i         (op_i),
        .alu_result_i (alu_result_i),
        .load_word_i  (load_word_i),
        .gpr_wdata_o  (s_gpr_wdata[0])
    );

    assign s_rd[0]        = rd_i;
    assign s_gpr_we[0]    = gpr_we_i;
    assign s_csr_we[0]    = csr_we_i;
    assign s_csr_addr[0]  = csr_addr_i;
    assign s_csr_wdata[0] = csr_wdata_i;
    assign s_irq[0]       = irq_i;
    assign s_irq_no[0]    = irq_no_i;
    assign s_is_break[0]  = is_break_i;

    for (genvar k = 0; k < PIPE_DEPTH; k++) begin : g_slice
        wb_pipe_slice u_slice (
            .clk         (clk),
            .reset       (reset),
            .flush_i     (flush_i),
            .in_valid_i  (s_valid[k]),
            .in_ready_o  (s_ready[k]),
            .out_valid_o (s_valid[k+1]),
            .out_ready_i (s_ready[k+1]),
            .rd_i        (s_rd[k]),
            .gpr_we_i    (s_gpr_we[k]),
            .gpr_wdata_i (s_gpr_wdata[k]),
            .csr_we_i    (s_csr_we[k]),
            .csr_addr_i  (s_csr_addr[k]),
            .csr_wdata_i (s_csr_wdata[k]),
            .irq_i       (s_irq[k]),
            .irq_no_i    (s_irq_no[k]),
            .is_break_i  (s_is_break[k]),
            .rd_o        (s_rd[k+1]),
            .gpr_we_o    (s_gpr_we[k+1]),
            .gpr_wdata_o (s_gpr_wdata[k+1]),
            .csr_we_o    (s_csr_we[k+1]),
            .csr_addr_o  (s_csr_addr[k+1]),
            .csr_wdata_o (s_csr_wdata[k+1]),
            .irq_o       (s_irq[k+1]),
            .irq_no_o    (s_irq_no[k+1]),
            .is_break_o  (s_is_break[k+1])
        );
    end

    wb_commit u_commit (
        .clk               (clk),
        .reset             (reset),
        .in_valid_i        (s_valid[PIPE_DEPTH]),
        .in_ready_o        (s_ready[PIPE_DEPTH]),
        .stall_i           (stall_i),
        .rd_i              (s_rd[PIPE_DEPTH]),
        .gpr_we_i          (s_gpr_we[PIPE_DEPTH]),
        .gpr_wdata_i       (s_gpr_wdata[PIPE_DEPTH]),
        .csr_we_i          (s_csr_we[PIPE_DEPTH]),
        .csr_addr_i        (s_csr_addr[PIPE_DEPTH]),
        .csr_wdata_i       (s_csr_wdata[PIPE_DEPTH]),
        .irq_i             (s_irq[PIPE_DEPTH]),
        .irq_no_i          (s_irq_no[PIPE_DEPTH]),
        .is_break_i        (s_is_break[PIPE_DEPTH]),
        .retire_valid_o    (retire_valid_o),
        .retire_gpr_we_o   (retire_gpr_we_o),
        .retire_rd_o       (retire_rd_o),
        .retire_gpr_data_o (retire_gpr_data_o),
        .retire_csr_we_o   (retire_csr_we_o),
        .retire_csr_addr_o (retire_csr_addr_o),
        .retire_csr_data_o (retire_csr_data_o),
        .retire_irq_o      (retire_irq_o),
        .halted_o          (halted_o),
        .dbg_rd_i          (dbg_rd_i),
        .dbg_gpr_data_o    (dbg_gpr_data_o)
    );

endmodule

`default_nettype wire
